// ==== src/core_cfg.svh ====
/*
 * core configuration
 * widths and depths shared by the out-of-order back end:
 * dispatch/issue/commit width, datapath, register and queue sizes
 */

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// instructions per bundle, issue slots and retire slots
`define CORE_WAYS 2
`define CORE_XLEN 32
// architectural registers
`define CORE_AREGS 8
`define CORE_ROB_DEPTH 8
`define CORE_RS_DEPTH 4
// load-immediate field
`define CORE_IMM_W 16

`endif

// ==== src/core_pkg.sv ====
/*
 * core types
 * opcode encoding and the packed structs that travel between
 * dispatch, reservation station, execute and reorder buffer
 */

`default_nettype none

`include "core_cfg.svh"

package core_pkg;

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_xor,
		op_li
	} op_e;

	typedef logic [$clog2(`CORE_AREGS)-1:0] areg_t;
	typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] rob_tag_t;

	// decoded instruction as it arrives
	typedef struct packed {
		logic valid;
		op_e op;
		areg_t rd;
		areg_t rs1;
		areg_t rs2;
		logic [`CORE_IMM_W-1:0] imm;
	} inst_t;

	// way 0 is older than way 1
	typedef struct packed {
		inst_t [`CORE_WAYS-1:0] way;
	} dispatch_bundle_t;

	// source operand, either a value or the tag it waits on
	typedef struct packed {
		logic ready;
		rob_tag_t tag;
		logic [`CORE_XLEN-1:0] value;
	} operand_t;

	typedef struct packed {
		logic valid;
		op_e op;
		rob_tag_t tag;
		logic [`CORE_IMM_W-1:0] imm;
		operand_t [1:0] src;
	} rs_entry_t;

	// common data bus slot
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic [`CORE_XLEN-1:0] data;
	} cdb_t;

	// tag goes out, done and value come back
	typedef struct packed {
		rob_tag_t tag;
		logic done;
		logic [`CORE_XLEN-1:0] value;
	} rob_lookup_t;

	typedef struct packed {
		logic valid;
		areg_t rd;
		logic [`CORE_XLEN-1:0] data;
	} commit_t;

endpackage

`default_nettype wire

// ==== src/dispatch_stage.sv ====
/*
 * dispatch stage
 * architectural register file with busy bits and producer tags,
 * operand capture for each way of the bundle, stall level
 */

`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module dispatch_stage
	import core_pkg::*;
(
	input wire logic clock,
	input wire logic rst_n,
	input wire dispatch_bundle_t bundle,
	input wire rob_tag_t [`CORE_WAYS-1:0] alloc_tag,
	input wire logic rob_free,
	input wire logic rs_free,
	input wire cdb_t [`CORE_WAYS-1:0] cdb,
	input wire commit_t [`CORE_WAYS-1:0] commit,
	output rob_lookup_t [2*`CORE_WAYS-1:0] rob_query,
	input wire rob_lookup_t [2*`CORE_WAYS-1:0] rob_answer,
	output logic rs_write,
	output rs_entry_t [`CORE_WAYS-1:0] rs_entries,
	output logic stall
);

	logic [`CORE_XLEN-1:0] arf [`CORE_AREGS];
	logic [`CORE_AREGS-1:0] busy;
	rob_tag_t tag_of [`CORE_AREGS];
	// mirrors the rob head, gives the tag of each commit slot
	rob_tag_t retire_ptr;
	rob_tag_t [`CORE_WAYS-1:0] commit_tag;
	logic [$clog2(`CORE_WAYS):0] n_commit;

	function automatic areg_t src_reg(inst_t ins, int s);
		return (s == 0) ? ins.rs1 : ins.rs2;
	endfunction

	// occupancy only, two free slots on both sides
	assign stall = ~rob_free | ~rs_free;
	assign rs_write = bundle.way[0].valid & ~stall;

	//////////////////////////////////////////////////////////////////////
	// operand capture
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		areg_t r;
		operand_t opnd;
		logic fwd;
		rob_tag_t fwd_tag;
		rs_entries = '0;
		rob_query = '0;
		for (int w = 0; w < `CORE_WAYS; w++) begin
			rs_entries[w].valid = bundle.way[w].valid;
			rs_entries[w].op = bundle.way[w].op;
			rs_entries[w].tag = alloc_tag[w];
			rs_entries[w].imm = bundle.way[w].imm;
			for (int s = 0; s < 2; s++) begin
				r = src_reg(bundle.way[w], s);
				rob_query[2*w+s].tag = tag_of[r];
				// newest older way of this bundle that writes r
				fwd = 1'b0;
				fwd_tag = '0;
				for (int k = 0; k < w; k++) begin
					if (bundle.way[k].valid && bundle.way[k].rd == r) begin
						fwd = 1'b1;
						fwd_tag = alloc_tag[k];
					end
				end
				opnd = '0;
				if (bundle.way[w].op == op_li) begin
					// li reads no register
					opnd.ready = 1'b1;
				end else if (fwd) begin
					opnd.tag = fwd_tag;
				end else if (!busy[r]) begin
					opnd.ready = 1'b1;
					opnd.value = arf[r];
				end else if (rob_answer[2*w+s].done) begin
					opnd.ready = 1'b1;
					opnd.value = rob_answer[2*w+s].value;
				end else begin
					opnd.tag = tag_of[r];
					// result on the bus right now
					for (int c = 0; c < `CORE_WAYS; c++) begin
						if (cdb[c].valid && cdb[c].tag == tag_of[r]) begin
							opnd.ready = 1'b1;
							opnd.value = cdb[c].data;
						end
					end
				end
				rs_entries[w].src[s] = opnd;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register state
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		n_commit = '0;
		for (int c = 0; c < `CORE_WAYS; c++) begin
			commit_tag[c] = retire_ptr + rob_tag_t'(c);
			n_commit = n_commit + commit[c].valid;
		end
	end

	// commits first, then the new producers of this bundle win
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy <= '0;
			retire_ptr <= '0;
			for (int i = 0; i < `CORE_AREGS; i++) begin
				arf[i] <= '0;
			end
		end else begin
			for (int c = 0; c < `CORE_WAYS; c++) begin
				if (commit[c].valid) begin
					arf[commit[c].rd] <= commit[c].data;
					// a younger producer keeps the register busy
					if (tag_of[commit[c].rd] == commit_tag[c])
						busy[commit[c].rd] <= 1'b0;
				end
			end
			if (rs_write) begin
				for (int w = 0; w < `CORE_WAYS; w++) begin
					if (bundle.way[w].valid)
						busy[bundle.way[w].rd] <= 1'b1;
				end
			end
			retire_ptr <= retire_ptr + n_commit;
		end
	end

	always_ff @(posedge clock) begin
		if (rs_write) begin
			for (int w = 0; w < `CORE_WAYS; w++) begin
				if (bundle.way[w].valid)
					tag_of[bundle.way[w].rd] <= alloc_tag[w];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/reservation_station.sv ====
/*
 * reservation station
 * age-ordered queue of waiting instructions, wakeup from the CDB,
 * up to two oldest ready entries issued per cycle
 */

`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module reservation_station
	import core_pkg::*;
(
	input wire logic clock,
	input wire logic rst_n,
	input wire logic rs_write,
	input wire rs_entry_t [`CORE_WAYS-1:0] rs_entries,
	input wire cdb_t [`CORE_WAYS-1:0] cdb,
	output rs_entry_t [`CORE_WAYS-1:0] issue,
	output logic rs_free
);

	localparam int CNT_W = $clog2(`CORE_RS_DEPTH) + 1;

	// slot 0 is the oldest, valid slots stay packed at the bottom
	rs_entry_t [`CORE_RS_DEPTH-1:0] slot;
	rs_entry_t [`CORE_RS_DEPTH-1:0] upd;
	rs_entry_t [`CORE_RS_DEPTH-1:0] nxt;
	logic [`CORE_RS_DEPTH-1:0] ready_v;
	logic [`CORE_RS_DEPTH-1:0] issued;
	logic [CNT_W-1:0] used;

	// wakeup, lands in the slot at the next edge
	always_comb begin
		upd = slot;
		for (int i = 0; i < `CORE_RS_DEPTH; i++) begin
			for (int s = 0; s < 2; s++) begin
				for (int c = 0; c < `CORE_WAYS; c++) begin
					if (slot[i].valid && !slot[i].src[s].ready && cdb[c].valid &&
							cdb[c].tag == slot[i].src[s].tag) begin
						upd[i].src[s].ready = 1'b1;
						upd[i].src[s].value = cdb[c].data;
					end
				end
			end
			// stored readiness only
			ready_v[i] = slot[i].valid & slot[i].src[0].ready & slot[i].src[1].ready;
		end
	end

	// oldest ready first
	always_comb begin
		int n;
		n = 0;
		issue = '0;
		issued = '0;
		for (int i = 0; i < `CORE_RS_DEPTH; i++) begin
			if (ready_v[i] && n < `CORE_WAYS) begin
				issue[n] = slot[i];
				issued[i] = 1'b1;
				n++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// compaction and insert
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		int k;
		k = 0;
		nxt = '0;
		// survivors keep their order
		for (int i = 0; i < `CORE_RS_DEPTH; i++) begin
			if (slot[i].valid && !issued[i]) begin
				nxt[k] = upd[i];
				k++;
			end
		end
		// new bundle goes behind them, way 0 first
		if (rs_write) begin
			for (int w = 0; w < `CORE_WAYS; w++) begin
				if (rs_entries[w].valid && k < `CORE_RS_DEPTH) begin
					nxt[k] = rs_entries[w];
					k++;
				end
			end
		end
	end

	always_comb begin
		used = '0;
		for (int i = 0; i < `CORE_RS_DEPTH; i++) begin
			used = used + slot[i].valid;
		end
	end

	assign rs_free = (used <= CNT_W'(`CORE_RS_DEPTH - 2));

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_RS_DEPTH; i++) begin
				slot[i].valid <= 1'b0;
			end
		end else begin
			slot <= nxt;
		end
	end

	// dispatch must have seen room for a full bundle
	a_rs_room: assert property (@(posedge clock) disable iff (!rst_n)
		rs_write |-> used <= CNT_W'(`CORE_RS_DEPTH - 2));

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
/*
 * execute unit
 * one single-cycle ALU per issue way, result registered
 * straight onto its common data bus slot
 */

`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module exec_unit
	import core_pkg::*;
(
	input wire logic clock,
	input wire logic rst_n,
	input wire rs_entry_t [`CORE_WAYS-1:0] issue,
	output cdb_t [`CORE_WAYS-1:0] cdb
);

	logic [`CORE_WAYS-1:0] valid_q;
	rob_tag_t [`CORE_WAYS-1:0] tag_q;
	logic [`CORE_WAYS-1:0][`CORE_XLEN-1:0] data_q;
	logic [`CORE_WAYS-1:0][`CORE_XLEN-1:0] result;

	function automatic logic [`CORE_XLEN-1:0] alu(rs_entry_t e);
		case (e.op)
			op_add: return e.src[0].value + e.src[1].value;
			op_sub: return e.src[0].value - e.src[1].value;
			op_and: return e.src[0].value & e.src[1].value;
			op_xor: return e.src[0].value ^ e.src[1].value;
			// zero-extended immediate
			op_li: return {{(`CORE_XLEN - `CORE_IMM_W){1'b0}}, e.imm};
			default: return '0;
		endcase
	endfunction

	always_comb begin
		for (int w = 0; w < `CORE_WAYS; w++) begin
			result[w] = alu(issue[w]);
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			valid_q <= '0;
		else
			for (int w = 0; w < `CORE_WAYS; w++) begin
				valid_q[w] <= issue[w].valid;
			end
	end

	// tag and data follow the issue slot unconditionally
	always_ff @(posedge clock) begin
		for (int w = 0; w < `CORE_WAYS; w++) begin
			tag_q[w] <= issue[w].tag;
			data_q[w] <= result[w];
		end
	end

	always_comb begin
		for (int w = 0; w < `CORE_WAYS; w++) begin
			cdb[w].valid = valid_q[w];
			cdb[w].tag = tag_q[w];
			cdb[w].data = data_q[w];
		end
	end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
/*
 * reorder buffer
 * circular queue indexed by tag with allocation at the tail,
 * completion from the CDB, operand lookup for dispatch and
 * in-order retire of up to two entries from the head
 */

`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module reorder_buffer
	import core_pkg::*;
(
	input wire logic clock,
	input wire logic rst_n,
	input wire logic accept,
	input wire dispatch_bundle_t bundle,
	input wire cdb_t [`CORE_WAYS-1:0] cdb,
	input wire rob_lookup_t [2*`CORE_WAYS-1:0] rob_query,
	output rob_lookup_t [2*`CORE_WAYS-1:0] rob_answer,
	output rob_tag_t [`CORE_WAYS-1:0] alloc_tag,
	output logic rob_free,
	output commit_t [`CORE_WAYS-1:0] commit
);

	localparam int CNT_W = $clog2(`CORE_ROB_DEPTH) + 1;

	logic [`CORE_ROB_DEPTH-1:0] ent_valid;
	logic [`CORE_ROB_DEPTH-1:0] ent_done;
	areg_t ent_rd [`CORE_ROB_DEPTH];
	logic [`CORE_XLEN-1:0] ent_data [`CORE_ROB_DEPTH];
	rob_tag_t head;
	rob_tag_t tail;
	logic [CNT_W-1:0] count;
	logic [$clog2(`CORE_WAYS):0] n_alloc;
	logic [$clog2(`CORE_WAYS):0] n_commit;

	assign rob_free = (count <= CNT_W'(`CORE_ROB_DEPTH - 2));

	// consecutive tags from the tail since valid ways are contiguous
	always_comb begin
		n_alloc = '0;
		for (int w = 0; w < `CORE_WAYS; w++) begin
			alloc_tag[w] = tail + rob_tag_t'(w);
			if (accept && bundle.way[w].valid)
				n_alloc = n_alloc + 1'b1;
		end
	end

	// same-cycle lookup for dispatch
	always_comb begin
		for (int q = 0; q < 2*`CORE_WAYS; q++) begin
			rob_answer[q].tag = rob_query[q].tag;
			rob_answer[q].done = ent_valid[rob_query[q].tag] & ent_done[rob_query[q].tag];
			rob_answer[q].value = ent_data[rob_query[q].tag];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// retire
	//////////////////////////////////////////////////////////////////////

	// a slot retires only if every older slot does too
	always_comb begin
		rob_tag_t idx;
		logic run;
		run = 1'b1;
		n_commit = '0;
		for (int w = 0; w < `CORE_WAYS; w++) begin
			idx = head + rob_tag_t'(w);
			commit[w].valid = run & ent_valid[idx] & ent_done[idx];
			commit[w].rd = ent_rd[idx];
			commit[w].data = ent_data[idx];
			run = commit[w].valid;
			n_commit = n_commit + commit[w].valid;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ent_valid <= '0;
			ent_done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			for (int w = 0; w < `CORE_WAYS; w++) begin
				if (commit[w].valid)
					ent_valid[head + rob_tag_t'(w)] <= 1'b0;
			end
			for (int c = 0; c < `CORE_WAYS; c++) begin
				if (cdb[c].valid)
					ent_done[cdb[c].tag] <= 1'b1;
			end
			// never overlaps a retiring slot as two free are required
			for (int w = 0; w < `CORE_WAYS; w++) begin
				if (accept && bundle.way[w].valid) begin
					ent_valid[alloc_tag[w]] <= 1'b1;
					ent_done[alloc_tag[w]] <= 1'b0;
				end
			end
			head <= head + n_commit;
			tail <= tail + n_alloc;
			count <= count + n_alloc - n_commit;
		end
	end

	always_ff @(posedge clock) begin
		for (int c = 0; c < `CORE_WAYS; c++) begin
			if (cdb[c].valid)
				ent_data[cdb[c].tag] <= cdb[c].data;
		end
		for (int w = 0; w < `CORE_WAYS; w++) begin
			if (accept && bundle.way[w].valid)
				ent_rd[alloc_tag[w]] <= bundle.way[w].rd;
		end
	end

	// retiring slots lie inside the occupied range
	for (genvar w = 0; w < `CORE_WAYS; w++) begin : g_chk
		a_commit_done: assert property (@(posedge clock) disable iff (!rst_n)
			commit[w].valid |-> count > w);
	end

	// the stall level from dispatch must cover this bundle
	a_alloc_room: assert property (@(posedge clock) disable iff (!rst_n)
		accept |-> n_alloc <= CNT_W'(`CORE_ROB_DEPTH) - count);

endmodule

`default_nettype wire

// ==== src/ooo_core.sv ====
/*
 * out-of-order core back end
 * dispatch, reservation station, execute and reorder buffer
 * joined by the common data bus
 */

`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module ooo_core
	import core_pkg::*;
(
	input wire logic clock,
	input wire logic rst_n,
	input wire dispatch_bundle_t bundle,
	output logic stall,
	output commit_t [`CORE_WAYS-1:0] commit
);

	rob_tag_t [`CORE_WAYS-1:0] alloc_tag;
	logic rob_free;
	logic rs_free;
	// bundle accepted this edge
	logic rs_write;
	rs_entry_t [`CORE_WAYS-1:0] rs_entries;
	rs_entry_t [`CORE_WAYS-1:0] issue;
	cdb_t [`CORE_WAYS-1:0] cdb;
	rob_lookup_t [2*`CORE_WAYS-1:0] rob_query;
	rob_lookup_t [2*`CORE_WAYS-1:0] rob_answer;

	dispatch_stage i_dispatch_stage (
		.clock (clock),
		.rst_n (rst_n),
		.bundle (bundle),
		.alloc_tag (alloc_tag),
		.rob_free (rob_free),
		.rs_free (rs_free),
		.cdb (cdb),
		.commit (commit),
		.rob_query (rob_query),
		.rob_answer (rob_answer),
		.rs_write (rs_write),
		.rs_entries (rs_entries),
		.stall (stall)
	);

	reservation_station i_reservation_station (
		.clock (clock),
		.rst_n (rst_n),
		.rs_write (rs_write),
		.rs_entries (rs_entries),
		.cdb (cdb),
		.issue (issue),
		.rs_free (rs_free)
	);

	exec_unit i_exec_unit (
		.clock (clock),
		.rst_n (rst_n),
		.issue (issue),
		.cdb (cdb)
	);

	reorder_buffer i_reorder_buffer (
		.clock (clock),
		.rst_n (rst_n),
		.accept (rs_write),
		.bundle (bundle),
		.cdb (cdb),
		.rob_query (rob_query),
		.rob_answer (rob_answer),
		.alloc_tag (alloc_tag),
		.rob_free (rob_free),
		.commit (commit)
	);

endmodule

`default_nettype wire

// ==== tb/core_model.svh ====
/*
 * in-order reference model
 * architectural registers updated in program order and the queue
 * of retirements the core is expected to produce
 */

`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// register state after every accepted instruction
logic [`CORE_XLEN-1:0] model_regs [`CORE_AREGS];
// oldest expected retirement at the front
commit_t exp_q [$];
int accepted_insts = 0;

// result of one instruction against the current model state
function automatic logic [`CORE_XLEN-1:0] reference_result(inst_t ins);
	logic [`CORE_XLEN-1:0] a;
	logic [`CORE_XLEN-1:0] b;
	a = model_regs[ins.rs1];
	b = model_regs[ins.rs2];
	case (ins.op)
		op_add: return a + b;
		op_sub: return a - b;
		op_and: return a & b;
		op_xor: return a ^ b;
		// immediate, zero extended
		op_li: return `CORE_XLEN'(ins.imm);
		default: return '0;
	endcase
endfunction

task automatic clear_model();
	for (int i = 0; i < `CORE_AREGS; i++) begin
		model_regs[i] = '0;
	end
	exp_q.delete();
	accepted_insts = 0;
endtask

// way 0 first, way 1 then sees its write
task automatic predict_bundle(dispatch_bundle_t b);
	commit_t e;
	for (int w = 0; w < `CORE_WAYS; w++) begin
		if (b.way[w].valid) begin
			e.valid = 1'b1;
			e.rd = b.way[w].rd;
			e.data = reference_result(b.way[w]);
			model_regs[e.rd] = e.data;
			exp_q.push_back(e);
			accepted_insts++;
		end
	end
endtask

`endif

// ==== tb/tb_ooo_core.sv ====
/*
 * testbench for the out-of-order core
 * random bundles from an LFSR, in-order model of the expected
 * retirements, commit order and data checked as they appear
 */

`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module tb_ooo_core
	import core_pkg::*;
();

	localparam int N_RANDOM = 400;
	// bundles of the random test times cycles per bundle
	localparam int MAX_CYCLES = N_RANDOM * 20;
	localparam int DRAIN_LIMIT = 200;

	logic clock;
	logic rst_n;
	dispatch_bundle_t bundle;
	logic stall;
	commit_t [`CORE_WAYS-1:0] commit;

	logic [31:0] lfsr_state = 32'h20ee5888;
	int errors = 0;
	int cycles = 0;
	int committed_insts = 0;
	int stall_cycles = 0;
	int bundles_sent = 0;

	`include "core_model.svh"

	ooo_core i_ooo_core (
		.clock (clock),
		.rst_n (rst_n),
		.bundle (bundle),
		.stall (stall),
		.commit (commit)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic inst_t random_inst(bit only_li);
		inst_t ins;
		logic [2:0] code;
		code = 3'(take_bits(3));
		ins.valid = 1'b1;
		ins.op = only_li ? op_li : op_e'(code % 3'd5);
		ins.rd = areg_t'(take_bits(3));
		ins.rs1 = areg_t'(take_bits(3));
		ins.rs2 = areg_t'(take_bits(3));
		ins.imm = `CORE_IMM_W'(take_bits(`CORE_IMM_W));
		return ins;
	endfunction

	// drive on the falling edge, hold while stalled
	task automatic send_bundle(dispatch_bundle_t b);
		@(negedge clock);
		bundle = b;
		while (stall) begin
			stall_cycles++;
			@(negedge clock);
		end
		// stall is low up to the next rising edge, so it is taken there
		predict_bundle(b);
		bundles_sent++;
		@(posedge clock);
	endtask

	task automatic drain_pipeline();
		int n;
		n = 0;
		@(negedge clock);
		bundle = '0;
		while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
			@(posedge clock);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			$display("pipeline did not drain, %0d instructions never retired", exp_q.size());
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// commit monitor
	//////////////////////////////////////////////////////////////////////

	// commit is stable between rising edges
	always @(negedge clock) begin : commit_monitor
		commit_t e;
		if (rst_n) begin
			for (int w = 0; w < `CORE_WAYS; w++) begin
				if (commit[w].valid) begin
					committed_insts++;
					assert (exp_q.size() != 0) else begin
						$display("commit of r%0d seen with nothing outstanding", commit[w].rd);
						errors++;
					end
					if (exp_q.size() != 0) begin
						e = exp_q.pop_front();
						assert (commit[w].rd == e.rd && commit[w].data == e.data) else begin
							$display("FAIL %0t: way %0d retired r%0d=%h, expected r%0d=%h",
								$time, w, commit[w].rd, commit[w].data, e.rd, e.data);
							errors++;
						end
					end
				end
			end
		end
	end

	initial begin : watchdog
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("run stopped by timeout after %0d cycles", cycles);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		dispatch_bundle_t b;
		areg_t last_rd;
		int errs;
		rst_n = 1'b0;
		bundle = '0;
		clear_model();
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// idle core after reset
		errs = errors;
		repeat (10) begin
			@(negedge clock);
			assert (!stall && !commit[0].valid && !commit[1].valid) else begin
				$display("FAIL %0t: stall %b commit %b%b while idle",
					$time, stall, commit[1].valid, commit[0].valid);
				errors++;
			end
		end
		$display("test 1 idle after reset: %0d errors", errors - errs);

		// load immediates only
		errs = errors;
		repeat (20) begin
			b.way[0] = random_inst(1'b1);
			b.way[1] = random_inst(1'b1);
			b.way[1].valid = 1'(take_bits(1));
			send_bundle(b);
		end
		drain_pipeline();
		$display("test 2 load immediate order: %0d errors", errors - errs);

		// way 1 reads way 0, way 0 reads the previous bundle
		errs = errors;
		last_rd = '0;
		repeat (30) begin
			b.way[0] = random_inst(1'b0);
			b.way[1] = random_inst(1'b0);
			b.way[0].rs1 = last_rd;
			b.way[1].rs1 = b.way[0].rd;
			last_rd = b.way[1].rd;
			send_bundle(b);
		end
		drain_pipeline();
		$display("test 3 dependent chains: %0d errors", errors - errs);

		// long alu chains every cycle until the core pushes back
		errs = errors;
		stall_cycles = 0;
		repeat (24) begin
			b.way[0] = random_inst(1'b0);
			b.way[1] = random_inst(1'b0);
			b.way[0].op = op_e'(2'(take_bits(2)));
			b.way[1].op = op_e'(2'(take_bits(2)));
			b.way[0].rs1 = last_rd;
			b.way[0].rs2 = last_rd;
			b.way[1].rs1 = b.way[0].rd;
			last_rd = b.way[1].rd;
			send_bundle(b);
		end
		assert (stall_cycles > 0) else begin
			$display("stall never rose during the back-pressure test");
			errors++;
		end
		drain_pipeline();
		assert (committed_insts == accepted_insts) else begin
			$display("FAIL %0t: %0d commits for %0d accepted instructions",
				$time, committed_insts, accepted_insts);
			errors++;
		end
		$display("test 4 back-pressure, %0d stall cycles: %0d errors",
			stall_cycles, errors - errs);

		// random mix of all ops
		errs = errors;
		repeat (N_RANDOM) begin
			b.way[0] = random_inst(1'b0);
			b.way[1] = random_inst(1'b0);
			b.way[1].valid = 1'(take_bits(1));
			send_bundle(b);
		end
		drain_pipeline();
		$display("test 5 random mix of %0d bundles: %0d errors", N_RANDOM, errors - errs);

		$display("%0d bundles, %0d accepted, %0d committed, %0d errors",
			bundles_sent, accepted_insts, committed_insts, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
+incdir+tb
src/core_pkg.sv
src/dispatch_stage.sv
src/reservation_station.sv
src/exec_unit.sv
src/reorder_buffer.sv
src/ooo_core.sv
tb/tb_ooo_core.sv
